// File: Makefile
VERILATOR ?= verilator
TOP       ?= datapathCore_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= Simulation passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the run passes only if the pass message shows up in the simulator output
run: build
	./$(SIM) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
+incdir+src
+incdir+bench
src/cpuPkg.sv
src/registerFile.sv
src/restoringDivider.sv
src/arithmeticUnit.sv
src/controlSequencer.sv
src/datapathCore.sv
bench/datapathCore_tb.sv

// File: bench/testVectors.svh
`ifndef TEST_VECTORS_SVH
`define TEST_VECTORS_SVH

typedef enum logic [1:0] {
    LoadReg,   // preload one register through the MDR
    Exec,      // fetch and execute one instruction word
    PokeBusy   // execute, and pulse both strobes while busy
} entryKind;

typedef struct packed {
    entryKind          kind;
    cpuPkg::opcodeType opcode;
    logic [3:0]        ra;           // load target for LoadReg
    logic [3:0]        rb;
    logic [3:0]        rc;
    logic [31:0]       data;         // load value, or the immediate in bits 18:0
    logic [31:0]       expectLow;    // R[ra], or LO for mul and div
    logic [31:0]       expectHigh;   // HI for mul and div
} vectorEntry;

vectorEntry vectors[$];

function automatic void addEntry(input entryKind kind, input cpuPkg::opcodeType opcode,
                                 input logic [3:0] ra, input logic [3:0] rb,
                                 input logic [3:0] rc, input logic [31:0] data,
                                 input logic [31:0] expectLow, input logic [31:0] expectHigh);
    vectors.push_back(vectorEntry'{kind, opcode, ra, rb, rc, data, expectLow, expectHigh});
endfunction

// columns are kind, opcode, ra, rb, rc, data or immediate, expected low, expected high
function automatic void fillTable();
    addEntry(LoadReg, cpuPkg::Add, 4'd1, 4'd0, 4'd0, 32'h0000_0018, 32'h0000_0018, 32'h0);
    addEntry(LoadReg, cpuPkg::Add, 4'd2, 4'd0, 4'd0, 32'h0000_0012, 32'h0000_0012, 32'h0);
    addEntry(LoadReg, cpuPkg::Add, 4'd3, 4'd0, 4'd0, 32'h0000_0014, 32'h0000_0014, 32'h0);
    addEntry(Exec, cpuPkg::Add, 4'd4, 4'd1, 4'd2, 32'h0000_0000, 32'h0000_002A, 32'h0);
    addEntry(Exec, cpuPkg::Sub, 4'd5, 4'd2, 4'd1, 32'h0000_0000, 32'hFFFF_FFFA, 32'h0);
    addEntry(Exec, cpuPkg::And, 4'd6, 4'd1, 4'd3, 32'h0000_0000, 32'h0000_0010, 32'h0);
    addEntry(Exec, cpuPkg::Or, 4'd7, 4'd1, 4'd3, 32'h0000_0000, 32'h0000_001C, 32'h0);
    addEntry(Exec, cpuPkg::Addi, 4'd8, 4'd1, 4'd0, 32'h0007_FFFB, 32'h0000_0013, 32'h0);
    addEntry(Exec, cpuPkg::Addi, 4'd9, 4'd2, 4'd0, 32'h0000_0100, 32'h0000_0112, 32'h0);
    addEntry(Exec, cpuPkg::Addi, 4'd9, 4'd3, 4'd0, 32'h0007_FFE0, 32'hFFFF_FFF4, 32'h0);
    addEntry(LoadReg, cpuPkg::Add, 4'd10, 4'd0, 4'd0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0);
    addEntry(LoadReg, cpuPkg::Add, 4'd11, 4'd0, 4'd0, 32'h0001_0001, 32'h0001_0001, 32'h0);
    addEntry(Exec, cpuPkg::Mul, 4'd10, 4'd11, 4'd0, 32'h0, 32'hFFFE_FFFF, 32'h0001_0000);
    addEntry(Exec, cpuPkg::Div, 4'd1, 4'd2, 4'd0, 32'h0, 32'h0000_0001, 32'h0000_0006);
    addEntry(LoadReg, cpuPkg::Add, 4'd12, 4'd0, 4'd0, 32'h0000_0000, 32'h0000_0000, 32'h0);
    addEntry(Exec, cpuPkg::Div, 4'd11, 4'd12, 4'd0, 32'h0, 32'hFFFF_FFFF, 32'h0001_0001);
    addEntry(Exec, cpuPkg::Mul, 4'd1, 4'd2, 4'd0, 32'h0, 32'h0000_01B0, 32'h0000_0000);
    addEntry(Exec, cpuPkg::Div, 4'd10, 4'd3, 4'd0, 32'h0, 32'h0CCC_CCCC, 32'h0000_000F);
    addEntry(PokeBusy, cpuPkg::Add, 4'd13, 4'd1, 4'd3, 32'h0000_0000, 32'h0000_002C, 32'h0);
endfunction

`endif

// File: bench/datapathCore_tb.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module datapathCore_tb;

    localparam int doneLimit = 100;   // cycles before a missing done counts as an error
    localparam logic [3:0] pokeTarget = 4'd14;

    logic                   Clock;
    logic                   reset;
    logic                   loadStrobe;
    logic [3:0]             loadSelect;
    logic                   start;
    logic [`DATA_WIDTH-1:0] memData;
    logic [3:0]             readSelect;
    logic                   busy;
    logic                   done;
    logic [`DATA_WIDTH-1:0] readData;
    logic [`DATA_WIDTH-1:0] hiValue;
    logic [`DATA_WIDTH-1:0] loValue;
    logic [`DATA_WIDTH-1:0] pcValue;

    integer      seed;
    int          failCount;
    int          checkCount;
    int          watchdogCycles;
    bit          entryFailed;
    logic [31:0] expectedPc;

    `include "testVectors.svh"

    datapathCore i_datapathCore (
        .Clock      (Clock),
        .reset      (reset),
        .loadStrobe (loadStrobe),
        .loadSelect (loadSelect),
        .start      (start),
        .memData    (memData),
        .readSelect (readSelect),
        .busy       (busy),
        .done       (done),
        .readData   (readData),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .pcValue    (pcValue)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("FAIL %0t ns: %s got %h, expected %h", $time, name, got, expected);
            failCount++;
            entryFailed = 1'b1;
        end
    endtask

    task automatic readRegister(input logic [3:0] index, output logic [31:0] value);
        readSelect = index;
        #1;
        value = readData;   // combinational port, DUT is idle here
    endtask

    task automatic waitForDone(output int cycles);
        cycles = 0;
        while (!done && cycles < doneLimit) begin
            @(posedge Clock);
            #1;
            loadStrobe = 1'b0;   // strobes last one cycle
            start      = 1'b0;
            cycles++;
        end
        assert (done) else begin
            $display("Error at %0t ns: done did not arrive within %0d cycles", $time, doneLimit);
            failCount++;
            entryFailed = 1'b1;
        end
    endtask

    // each random entry preloads R15 and R14, then runs add, sub or div on them
    task automatic addRandomEntries();
        logic [31:0]       a;
        logic [31:0]       b;
        cpuPkg::opcodeType op;
        for (int n = 0; n < 10; n++) begin
            a = $random(seed);
            b = $random(seed);
            case ($unsigned($random(seed)) % 3)
                0: op = cpuPkg::Add;
                1: op = cpuPkg::Sub;
                default: op = cpuPkg::Div;
            endcase
            if (op == cpuPkg::Div) begin
                b = b >> ($unsigned($random(seed)) % 32);   // small divisors, larger quotients
            end
            addEntry(LoadReg, cpuPkg::Add, 4'd15, 4'd0, 4'd0, a, a, 32'h0);
            addEntry(LoadReg, cpuPkg::Add, 4'd14, 4'd0, 4'd0, b, b, 32'h0);
            if (op == cpuPkg::Add) begin
                addEntry(Exec, op, 4'd13, 4'd15, 4'd14, 32'h0, a + b, 32'h0);
            end else if (op == cpuPkg::Sub) begin
                addEntry(Exec, op, 4'd13, 4'd15, 4'd14, 32'h0, a - b, 32'h0);
            end else if (b == 32'h0) begin
                addEntry(Exec, op, 4'd15, 4'd14, 4'd0, 32'h0, 32'hFFFF_FFFF, a);
            end else begin
                addEntry(Exec, op, 4'd15, 4'd14, 4'd0, 32'h0, a / b, a % b);
            end
        end
    endtask

    task automatic applyEntry(input int index, input vectorEntry e);
        cpuPkg::instructionWord word;
        logic [31:0]            keptA;
        logic [31:0]            keptB;
        logic [31:0]            keptPoke;
        logic [31:0]            value;
        int                     latency;
        string                  label;
        entryFailed = 1'b0;
        readRegister(e.ra, keptA);
        readRegister(e.rb, keptB);
        readRegister(pokeTarget, keptPoke);
        word = '0;
        if (e.opcode == cpuPkg::Addi) begin
            word.immForm = '{e.opcode, e.ra, e.rb, e.data[18:0]};
        end else begin
            word.regForm = '{e.opcode, e.ra, e.rb, e.rc, 15'h0};   // div R1,R2 is 32'h80900000
        end
        @(posedge Clock);
        #1;
        memData    = (e.kind == LoadReg) ? e.data : word;
        loadSelect = e.ra;
        loadStrobe = (e.kind == LoadReg);
        start      = (e.kind != LoadReg);
        if (e.kind == PokeBusy) begin
            @(posedge Clock);
            #1;
            start = 1'b0;
            repeat (2) @(posedge Clock);
            #1;   // sequencer sits in T2 and MDR already holds the instruction
            {start, loadStrobe} = 2'b11;
            loadSelect = pokeTarget;
            memData    = 32'hA5A5_5A5A;
        end
        waitForDone(latency);
        @(posedge Clock);
        #1;
        if (e.kind == LoadReg) begin
            label = "load";
            checkValue("done latency", 32'(latency), 32'd2);
            readRegister(e.ra, value);
            checkValue("readData", value, e.expectLow);
        end else begin
            label = e.opcode.name();
            expectedPc = expectedPc + 32'd1;
            checkValue("pcValue", pcValue, expectedPc);
            if (e.opcode == cpuPkg::Mul || e.opcode == cpuPkg::Div) begin
                checkValue("hiValue", hiValue, e.expectHigh);
                checkValue("loValue", loValue, e.expectLow);
                readRegister(e.ra, value);
                checkValue("readData", value, keptA);
                readRegister(e.rb, value);
                checkValue("readData", value, keptB);
            end else begin
                readRegister(e.ra, value);
                checkValue("readData", value, e.expectLow);
            end
            if (e.kind == PokeBusy) begin
                checkValue("busy", {31'h0, busy}, 32'h0);
                readRegister(pokeTarget, value);
                checkValue("readData", value, keptPoke);
            end
        end
        memData = '0;
        $display("test %0d %s R%0d: %s", index, label, e.ra, entryFailed ? "FAILED" : "ok");
    endtask

    initial begin
        reset          = 1'b1;
        loadStrobe     = 1'b0;
        loadSelect     = '0;
        start          = 1'b0;
        memData        = '0;
        readSelect     = '0;
        seed           = 32'hf702_1cb2;
        failCount      = 0;
        checkCount     = 0;
        watchdogCycles = 0;
        expectedPc     = '0;
        fillTable();
        addRandomEntries();
        watchdogCycles = vectors.size() * 60;
        repeat (3) @(posedge Clock);
        #1;
        reset = 1'b0;
        foreach (vectors[i]) begin
            applyEntry(i, vectors[i]);
        end
        $display("%0d tests, %0d checks, %0d failures", vectors.size(), checkCount, failCount);
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clock);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: src/arithmeticUnit.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module arithmeticUnit (
    input  logic                   Clock,
    input  logic                   reset,
    input  cpuPkg::opcodeType      opcode,
    input  logic [`DATA_WIDTH-1:0] operandY,
    input  logic [`DATA_WIDTH-1:0] operandB,
    input  logic [18:0]            immediate,
    input  logic                   startDivide,
    output logic [`DATA_WIDTH-1:0] resultHigh,
    output logic [`DATA_WIDTH-1:0] resultLow,
    output logic                   aluDone
);

    localparam int width = `DATA_WIDTH;

    logic [width-1:0]   immExtended;
    logic [2*width-1:0] product;
    logic [width-1:0]   quotient;
    logic [width-1:0]   remainder;
    logic               divFinish;

    assign immExtended = {{(width - 19){immediate[18]}}, immediate};
    assign product     = operandY * operandB;   // unsigned, full 64 bits

    restoringDivider i_restoringDivider (
        .Clock       (Clock),
        .reset       (reset),
        .startDivide (startDivide),
        .dividend    (operandY),
        .divisor     (operandB),
        .quotient    (quotient),
        .remainder   (remainder),
        .finish      (divFinish)
    );

    always_comb begin
        resultHigh = '0;
        resultLow  = '0;
        aluDone    = 1'b1;   // single-cycle ops complete at once
        case (opcode)
            cpuPkg::Add: begin
                resultLow = operandY + operandB;
            end
            cpuPkg::Sub: begin
                resultLow = operandY - operandB;   // wraps modulo 2^32
            end
            cpuPkg::And: begin
                resultLow = operandY & operandB;
            end
            cpuPkg::Or: begin
                resultLow = operandY | operandB;
            end
            cpuPkg::Addi: begin
                resultLow = operandY + immExtended;
            end
            cpuPkg::Mul: begin
                resultHigh = product[2*width-1:width];
                resultLow  = product[width-1:0];
            end
            cpuPkg::Div: begin
                resultHigh = remainder;
                resultLow  = quotient;
                aluDone    = divFinish;   // holds T4 until the divider retires
            end
            default: begin
                resultLow = '0;
            end
        endcase
    end

endmodule

// File: src/controlSequencer.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module controlSequencer (
    input  logic                          Clock,
    input  logic                          reset,
    input  logic                          loadStrobe,
    input  logic [$clog2(`REG_COUNT)-1:0] loadSelect,
    input  logic                          start,
    input  cpuPkg::instructionWord        instruction,
    input  logic                          aluDone,
    output logic                          pcOut,
    output logic                          mdrOut,
    output logic                          zLowOut,
    output logic                          zHighOut,
    output logic [$clog2(`REG_COUNT)-1:0] regOutSelect,
    output logic                          regOutValid,
    output logic                          marEnable,
    output logic                          mdrEnable,
    output logic                          irEnable,
    output logic                          yEnable,
    output logic                          zEnable,
    output logic                          pcEnable,
    output logic                          hiEnable,
    output logic                          loEnable,
    output logic [`REG_COUNT-1:0]         regEnable,
    output logic                          incPc,
    output logic                          useImmediate,
    output logic                          startDivide,
    output logic                          busy,
    output logic                          done
);

    cpuPkg::stepType                 step;
    logic [$clog2(`REG_COUNT)-1:0]   loadTarget;
    logic                            execEntry;
    cpuPkg::opcodeType               opcode;
    logic                            isMulDiv;
    logic                            isImmediate;

    assign opcode      = instruction.regForm.opcode;
    assign isMulDiv    = (opcode == cpuPkg::Mul) || (opcode == cpuPkg::Div);
    assign isImmediate = (instruction.immForm.opcode == cpuPkg::Addi);

    always_ff @(posedge Clock) begin
        if (reset) begin
            step       <= cpuPkg::Idle;
            loadTarget <= '0;
            execEntry  <= 1'b0;
        end else begin
            execEntry <= (step == cpuPkg::T3);   // high in the first T4 cycle
            case (step)
                cpuPkg::Idle: begin
                    if (loadStrobe) begin
                        step       <= cpuPkg::LoadA;
                        loadTarget <= loadSelect;
                    end else if (start) begin
                        step <= cpuPkg::T0;
                    end
                end
                cpuPkg::LoadA: step <= cpuPkg::LoadB;
                cpuPkg::LoadB: step <= cpuPkg::Idle;
                cpuPkg::T0:    step <= cpuPkg::T1;
                cpuPkg::T1:    step <= cpuPkg::T2;
                cpuPkg::T2:    step <= cpuPkg::T3;
                cpuPkg::T3:    step <= cpuPkg::T4;
                cpuPkg::T4:    step <= aluDone ? cpuPkg::T5 : cpuPkg::T4;
                default:       step <= cpuPkg::Idle;
            endcase
        end
    end

    always_comb begin
        {pcOut, mdrOut, zLowOut, zHighOut, regOutValid} = '0;
        {marEnable, mdrEnable, irEnable, yEnable, zEnable} = '0;
        {pcEnable, hiEnable, loEnable, incPc, useImmediate, startDivide, done} = '0;
        regOutSelect = '0;
        regEnable    = '0;
        case (step)
            cpuPkg::LoadA: mdrEnable = 1'b1;
            cpuPkg::LoadB: begin
                mdrOut                = 1'b1;
                regEnable[loadTarget] = 1'b1;
                done                  = 1'b1;
            end
            cpuPkg::T0: begin
                {pcOut, marEnable, zEnable, incPc} = '1;   // Z gets PC+1
            end
            cpuPkg::T1: {zLowOut, pcEnable, mdrEnable} = '1;
            cpuPkg::T2: {mdrOut, irEnable} = '1;
            cpuPkg::T3: begin
                regOutValid  = 1'b1;
                regOutSelect = isMulDiv ? instruction.regForm.ra : instruction.regForm.rb;
                yEnable      = 1'b1;
            end
            cpuPkg::T4: begin
                if (isImmediate) begin
                    useImmediate = 1'b1;   // second operand is the constant, bus idle
                end else begin
                    regOutValid  = 1'b1;
                    regOutSelect = isMulDiv ? instruction.regForm.rb : instruction.regForm.rc;
                end
                startDivide = execEntry && (opcode == cpuPkg::Div);
                zEnable     = aluDone;
            end
            cpuPkg::T5: begin
                done = 1'b1;
                if (isMulDiv) begin
                    {zHighOut, hiEnable, loEnable} = '1;   // LO loads straight from ZLow
                end else begin
                    zLowOut                           = 1'b1;
                    regEnable[instruction.regForm.ra] = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign busy = (step != cpuPkg::Idle);

    // the top-level OR multiplexer relies on a single driver per cycle
    oneBusSource: assert property (@(posedge Clock) disable iff (reset)
        $onehot0({pcOut, mdrOut, zLowOut, zHighOut, regOutValid}))
        else $error("controlSequencer: several bus sources selected");

endmodule

// File: src/cpuPkg.sv
package cpuPkg;

    typedef enum logic [4:0] {
        Add  = 5'b00011,
        Sub  = 5'b00100,
        And  = 5'b00101,
        Or   = 5'b00110,
        Addi = 5'b01100,
        Mul  = 5'b01111,
        Div  = 5'b10000
    } opcodeType;

    typedef enum logic [3:0] {
        Idle,
        LoadA,   // MDR takes host data
        LoadB,   // MDR written to target register
        T0,
        T1,
        T2,
        T3,
        T4,
        T5
    } stepType;

    typedef struct packed {
        opcodeType   opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } regFormType;

    typedef struct packed {
        opcodeType   opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] imm;   // sign-extended by the ALU
    } immFormType;

    // one IR word, read as register form or immediate form
    typedef union packed {
        regFormType regForm;
        immFormType immForm;
    } instructionWord;

endpackage

// File: src/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// width of the internal bus and of every datapath register
`define DATA_WIDTH 32

// number of general registers, indexed by 4-bit fields
`define REG_COUNT 16

`endif

// File: src/datapathCore.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module datapathCore (
    input  logic                          Clock,
    input  logic                          reset,
    input  logic                          loadStrobe,
    input  logic [$clog2(`REG_COUNT)-1:0] loadSelect,
    input  logic                          start,
    input  logic [`DATA_WIDTH-1:0]        memData,
    input  logic [$clog2(`REG_COUNT)-1:0] readSelect,
    output logic                          busy,
    output logic                          done,
    output logic [`DATA_WIDTH-1:0]        readData,
    output logic [`DATA_WIDTH-1:0]        hiValue,
    output logic [`DATA_WIDTH-1:0]        loValue,
    output logic [`DATA_WIDTH-1:0]        pcValue
);

    localparam int width = `DATA_WIDTH;

    logic [width-1:0]              busData;
    logic [width-1:0]              regBusValue;
    logic [width-1:0]              pcReg, marReg, mdrReg, yReg;
    logic [width-1:0]              zHigh, zLow, hiReg, loReg;
    logic [width-1:0]              aluHigh, aluLow;
    cpuPkg::instructionWord        irReg;
    logic [18:0]                   aluImmediate;
    logic                          pcOut, mdrOut, zLowOut, zHighOut, regOutValid;
    logic [$clog2(`REG_COUNT)-1:0] regOutSelect;
    logic                          marEnable, mdrEnable, irEnable, yEnable, zEnable;
    logic                          pcEnable, hiEnable, loEnable;
    logic [`REG_COUNT-1:0]         regEnable;
    logic                          incPc, useImmediate, startDivide, aluDone;

    // selected sources are ORed onto the shared bus
    assign busData = ({width{pcOut}}       & pcReg)
                   | ({width{mdrOut}}      & mdrReg)
                   | ({width{zLowOut}}     & zLow)
                   | ({width{zHighOut}}    & zHigh)
                   | ({width{regOutValid}} & regBusValue);

    assign aluImmediate = useImmediate ? irReg.immForm.imm : '0;   // only shown during addi

    always_ff @(posedge Clock) begin
        if (reset) begin
            {pcReg, marReg, mdrReg, yReg, zHigh, zLow, hiReg, loReg} <= '0;
            irReg <= '0;
        end else begin
            if (pcEnable)  pcReg  <= busData;
            if (marEnable) marReg <= busData;
            if (mdrEnable) mdrReg <= memData;   // no store path, MDR only reads memory
            if (irEnable)  irReg  <= busData;
            if (yEnable)   yReg   <= busData;
            if (zEnable)   {zHigh, zLow} <= incPc ? {{width{1'b0}}, busData + 1'b1}
                                                  : {aluHigh, aluLow};
            if (hiEnable)  hiReg  <= busData;
            if (loEnable)  loReg  <= zLow;
        end
    end

    registerFile i_registerFile (
        .Clock (Clock), .reset (reset), .busData (busData), .writeEnable (regEnable),
        .readSelect (readSelect), .busSelect (regOutSelect), .busValue (regBusValue),
        .readData (readData)
    );

    arithmeticUnit i_arithmeticUnit (
        .Clock (Clock), .reset (reset), .opcode (irReg.regForm.opcode), .operandY (yReg),
        .operandB (busData), .immediate (aluImmediate), .startDivide (startDivide),
        .resultHigh (aluHigh), .resultLow (aluLow), .aluDone (aluDone)
    );

    controlSequencer i_controlSequencer (
        .Clock (Clock), .reset (reset), .loadStrobe (loadStrobe), .loadSelect (loadSelect),
        .start (start), .instruction (irReg), .aluDone (aluDone), .pcOut (pcOut),
        .mdrOut (mdrOut), .zLowOut (zLowOut), .zHighOut (zHighOut),
        .regOutSelect (regOutSelect), .regOutValid (regOutValid), .marEnable (marEnable),
        .mdrEnable (mdrEnable), .irEnable (irEnable), .yEnable (yEnable), .zEnable (zEnable),
        .pcEnable (pcEnable), .hiEnable (hiEnable), .loEnable (loEnable),
        .regEnable (regEnable), .incPc (incPc), .useImmediate (useImmediate),
        .startDivide (startDivide), .busy (busy), .done (done)
    );

    assign hiValue = hiReg;
    assign loValue = loReg;
    assign pcValue = pcReg;

    // fetch leaves PC one past the address latched into MAR
    pcFollowsMar: assert property (@(posedge Clock) disable iff (reset)
        pcEnable |=> (pcReg == marReg + 1))
        else $error("datapathCore: PC does not follow the fetch address");

endmodule

// File: src/registerFile.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module registerFile (
    input  logic                          Clock,
    input  logic                          reset,
    input  logic [`DATA_WIDTH-1:0]        busData,
    input  logic [`REG_COUNT-1:0]         writeEnable,
    input  logic [$clog2(`REG_COUNT)-1:0] readSelect,
    input  logic [$clog2(`REG_COUNT)-1:0] busSelect,
    output logic [`DATA_WIDTH-1:0]        busValue,
    output logic [`DATA_WIDTH-1:0]        readData
);

    logic [`DATA_WIDTH-1:0] generalRegs [`REG_COUNT];

    always_ff @(posedge Clock) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (reset) begin
                generalRegs[i] <= '0;
            end else if (writeEnable[i]) begin
                generalRegs[i] <= busData;   // every register loads from the bus
            end
        end
    end

    assign busValue = generalRegs[busSelect];   // feeds the bus multiplexer
    assign readData = generalRegs[readSelect];  // host observation port

    // the sequencer must never target two registers in one cycle
    singleWrite: assert property (@(posedge Clock) disable iff (reset)
        $onehot0(writeEnable))
        else $error("registerFile: more than one write enable set");

endmodule

// File: src/restoringDivider.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module restoringDivider (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   startDivide,
    input  logic [`DATA_WIDTH-1:0] dividend,
    input  logic [`DATA_WIDTH-1:0] divisor,
    output logic [`DATA_WIDTH-1:0] quotient,
    output logic [`DATA_WIDTH-1:0] remainder,
    output logic                   finish
);

    localparam int width = `DATA_WIDTH;
    localparam int lastStep = width - 1;

    logic                         active;
    logic [$clog2(width)-1:0]     stepCount;
    logic [width-1:0]             quoReg;
    logic [width-1:0]             remReg;
    logic [width-1:0]             divReg;
    logic [width:0]               shifted;
    logic [width:0]               trial;
    logic                         zeroDivisor;

    assign zeroDivisor = (divisor == '0);

    // next dividend bit enters the partial remainder, then a trial subtract
    assign shifted = {remReg, quoReg[width-1]};
    assign trial   = shifted - {1'b0, divReg};

    always_ff @(posedge Clock) begin
        if (reset) begin
            active    <= 1'b0;
            stepCount <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (startDivide && zeroDivisor) begin
                finish <= 1'b1;   // defined result, no iterations
            end else if (startDivide) begin
                active    <= 1'b1;
                stepCount <= '0;
            end else if (active) begin
                stepCount <= stepCount + 1'b1;
                if (stepCount == lastStep[$clog2(width)-1:0]) begin
                    active <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (startDivide) begin
            divReg <= divisor;
            quoReg <= zeroDivisor ? '1 : dividend;
            remReg <= zeroDivisor ? dividend : '0;
        end else if (active) begin
            quoReg <= {quoReg[width-2:0], ~trial[width]};   // no borrow gives a one
            if (!trial[width]) begin
                remReg <= trial[width-1:0];
            end else begin
                remReg <= shifted[width-1:0];   // restore
            end
        end
    end

    assign quotient  = quoReg;
    assign remainder = remReg;

    // a new divide may only be requested once the previous one has retired
    noRestart: assert property (@(posedge Clock) disable iff (reset)
        startDivide |-> !active)
        else $error("restoringDivider: start while a division is running");

endmodule
